/* rs_issue_pkg.sv */
package rs_issue_pkg;

    // Major opcode values, bits [6:0] of the instruction.
    typedef enum logic [6:0] {
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011,
        SYSTEM = 7'b1110011
    } opcode_t;

    localparam int PHY_REGS = 64;

    typedef logic [5:0] phy_tag_t;

    // Relative age, 0 is the oldest occupied entry.
    typedef logic [3:0] age_t;

    typedef struct packed {
        logic     valid;
        opcode_t  opcode;
        phy_tag_t rs1_phy;
        phy_tag_t rs2_phy;
        phy_tag_t rd_phy;
        age_t     age;
    } rs_entry_t;

endpackage

/* rs_select_if.sv */
`timescale 1ns/1ps

interface rs_select_if import rs_issue_pkg::*; #(
    parameter int NUM_RS_ENTRIES = 16
);

    rs_entry_t                           entries [NUM_RS_ENTRIES];
    logic [PHY_REGS-1:0]                 prf_valid;  // Ready bit per register.
    logic [$clog2(NUM_RS_ENTRIES)-1:0]   best;
    logic                                best_valid;

    modport table_mp (
        output entries,
        input  best,
        input  best_valid
    );

    modport select_mp (
        input  entries,
        input  prf_valid,
        output best,
        output best_valid
    );

endinterface

/* prf_scoreboard.sv */
`timescale 1ns/1ps

module prf_scoreboard import rs_issue_pkg::*; #(
    parameter int PHY_REGS = rs_issue_pkg::PHY_REGS
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                alloc_valid,
    input  phy_tag_t            alloc_phy,
    input  logic                wb_valid,
    input  phy_tag_t            wb_phy,
    output logic [PHY_REGS-1:0] prf_valid
);

    logic [PHY_REGS-1:0] ready_q;
    logic [PHY_REGS-1:0] ready_d;

    always_comb begin
        ready_d = ready_q;
        if (wb_valid) begin
            ready_d[wb_phy] = 1'b1;  // Result written back.
        end
        // A new destination is pending again.
        // Placed last so it overrides a writeback to the same tag.
        if (alloc_valid) begin
            ready_d[alloc_phy] = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ready_q <= '1;  // Architectural state is ready.
        end else begin
            ready_q <= ready_d;
        end
    end

    assign prf_valid = ready_q;

endmodule

/* rs_table.sv */
`timescale 1ns/1ps

module rs_table import rs_issue_pkg::*; #(
    parameter int NUM_RS_ENTRIES = 16
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              dispatch_valid,
    input  opcode_t           dispatch_opcode,
    input  phy_tag_t          dispatch_rs1,
    input  phy_tag_t          dispatch_rs2,
    input  phy_tag_t          dispatch_rd,
    output logic              rs_full,
    rs_select_if.table_mp     sel
);

    localparam int IDX_W = $clog2(NUM_RS_ENTRIES);

    rs_entry_t               rs_q [NUM_RS_ENTRIES];
    logic [NUM_RS_ENTRIES-1:0] valid_vec;
    logic [IDX_W:0]          occ_cnt;
    logic [IDX_W-1:0]        alloc_idx;
    logic                    alloc_found;
    logic                    accept;
    age_t                    freed_age;
    age_t                    new_age;
    rs_entry_t               new_entry;

    // Occupancy and lowest free slot.
    always_comb begin
        valid_vec   = '0;
        occ_cnt     = '0;
        alloc_idx   = '0;
        alloc_found = 1'b0;
        for (int i = 0; i < NUM_RS_ENTRIES; i++) begin
            valid_vec[i] = rs_q[i].valid;
            if (rs_q[i].valid) begin
                occ_cnt = occ_cnt + 1'b1;
            end else if (!alloc_found) begin
                alloc_idx   = IDX_W'(i);
                alloc_found = 1'b1;
            end
        end
    end

    assign rs_full = &valid_vec;
    assign accept  = dispatch_valid && !rs_full && alloc_found;

    assign freed_age = rs_q[sel.best].age;

    // Youngest position once this cycle's issue has left.
    assign new_age = age_t'(occ_cnt - {{IDX_W{1'b0}}, sel.best_valid});

    always_comb begin
        new_entry         = '0;
        new_entry.valid   = 1'b1;
        new_entry.opcode  = dispatch_opcode;
        new_entry.rs1_phy = dispatch_rs1;
        new_entry.rs2_phy = dispatch_rs2;
        new_entry.rd_phy  = dispatch_rd;
        new_entry.age     = new_age;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_RS_ENTRIES; i++) begin
                rs_q[i].valid <= 1'b0;
            end
        end else begin
            if (sel.best_valid) begin
                // Close the gap left by the issued entry.
                for (int i = 0; i < NUM_RS_ENTRIES; i++) begin
                    if (rs_q[i].valid && rs_q[i].age > freed_age) begin
                        rs_q[i].age <= rs_q[i].age - 1'b1;
                    end
                end
                rs_q[sel.best].valid <= 1'b0;
            end
            if (accept) begin
                rs_q[alloc_idx] <= new_entry;  // Slot was free, never the issued one.
            end
        end
    end

    assign sel.entries = rs_q;

endmodule

/* issue_select.sv */
`timescale 1ns/1ps

module issue_select import rs_issue_pkg::*; #(
    parameter int NUM_RS_ENTRIES = 16
) (
    rs_select_if.select_mp sel
);

    localparam int IDX_W = $clog2(NUM_RS_ENTRIES);

    logic [NUM_RS_ENTRIES-1:0] rs1_rdy;
    logic [NUM_RS_ENTRIES-1:0] rs2_rdy;
    logic [NUM_RS_ENTRIES-1:0] cand;
    logic [IDX_W-1:0]          win_idx;
    age_t                      win_age;
    logic                      found;
    logic                      blocked;

    // Per-class readiness.
    always_comb begin
        cand = '0;
        for (int i = 0; i < NUM_RS_ENTRIES; i++) begin
            rs1_rdy[i] = sel.prf_valid[sel.entries[i].rs1_phy];
            rs2_rdy[i] = sel.prf_valid[sel.entries[i].rs2_phy];
            if (sel.entries[i].valid) begin
                case (sel.entries[i].opcode)
                    LOAD, STORE:              cand[i] = 1'b1;  // Checked after the pick.
                    JAL, LUI, AUIPC, SYSTEM:  cand[i] = 1'b1;
                    OP_IMM, JALR:             cand[i] = rs1_rdy[i];
                    OP, BRANCH:               cand[i] = rs1_rdy[i] && rs2_rdy[i];
                    default:                  cand[i] = 1'b0;
                endcase
            end
        end
    end

    // Oldest candidate wins.
    always_comb begin
        found   = 1'b0;
        win_idx = '0;
        win_age = '0;
        for (int i = 0; i < NUM_RS_ENTRIES; i++) begin
            if (cand[i] && (!found || sel.entries[i].age < win_age)) begin
                found   = 1'b1;
                win_idx = IDX_W'(i);
                win_age = sel.entries[i].age;
            end
        end
    end

    // An unready memory op at the head stalls issue.
    always_comb begin
        blocked = 1'b0;
        if (sel.entries[win_idx].opcode == LOAD) begin
            blocked = !rs1_rdy[win_idx];
        end else if (sel.entries[win_idx].opcode == STORE) begin
            blocked = !(rs1_rdy[win_idx] && rs2_rdy[win_idx]);
        end
    end

    assign sel.best       = win_idx;
    assign sel.best_valid = found && !blocked;

endmodule

/* rs_issue_top.sv */
`timescale 1ns/1ps

module rs_issue_top import rs_issue_pkg::*; #(
    parameter int NUM_RS_ENTRIES = 16,
    parameter int PHY_REGS       = rs_issue_pkg::PHY_REGS
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     dispatch_valid,
    input  opcode_t  dispatch_opcode,
    input  phy_tag_t dispatch_rs1,
    input  phy_tag_t dispatch_rs2,
    input  phy_tag_t dispatch_rd,
    output logic     rs_full,
    input  logic     wb_valid,
    input  phy_tag_t wb_phy,
    output logic     issue_valid,
    output opcode_t  issue_opcode,
    output phy_tag_t issue_rs1,
    output phy_tag_t issue_rs2,
    output phy_tag_t issue_rd
);

    if ((2 ** $bits(age_t)) < NUM_RS_ENTRIES) begin : g_age_check
        $error("age_t too narrow for NUM_RS_ENTRIES");
    end

    if (PHY_REGS != rs_issue_pkg::PHY_REGS) begin : g_prf_check
        $error("PHY_REGS must match the package value");
    end

    logic            alloc_valid;
    logic [PHY_REGS-1:0] prf_valid;
    rs_entry_t       issue_entry;

    rs_select_if #(.NUM_RS_ENTRIES(NUM_RS_ENTRIES)) sel_if ();

    assign alloc_valid = dispatch_valid && !rs_full;  // Dropped when full.

    prf_scoreboard #(.PHY_REGS(PHY_REGS)) u_scoreboard (
        .clk         (clk),
        .reset       (reset),
        .alloc_valid (alloc_valid),
        .alloc_phy   (dispatch_rd),
        .wb_valid    (wb_valid),
        .wb_phy      (wb_phy),
        .prf_valid   (prf_valid)
    );

    assign sel_if.prf_valid = prf_valid;

    rs_table #(.NUM_RS_ENTRIES(NUM_RS_ENTRIES)) u_table (
        .clk             (clk),
        .reset           (reset),
        .dispatch_valid  (dispatch_valid),
        .dispatch_opcode (dispatch_opcode),
        .dispatch_rs1    (dispatch_rs1),
        .dispatch_rs2    (dispatch_rs2),
        .dispatch_rd     (dispatch_rd),
        .rs_full         (rs_full),
        .sel             (sel_if.table_mp)
    );

    issue_select #(.NUM_RS_ENTRIES(NUM_RS_ENTRIES)) u_select (
        .sel (sel_if.select_mp)
    );

    assign issue_entry  = sel_if.entries[sel_if.best];
    assign issue_valid  = sel_if.best_valid;
    assign issue_opcode = issue_entry.opcode;
    assign issue_rs1    = issue_entry.rs1_phy;
    assign issue_rs2    = issue_entry.rs2_phy;
    assign issue_rd     = issue_entry.rd_phy;

endmodule

/* rs_issue_assert.sv */
`timescale 1ns/1ps

module rs_issue_assert import rs_issue_pkg::*; #(
    parameter int NUM_RS_ENTRIES = 16
) (
    input logic                              clk,
    input logic                              reset,
    input rs_entry_t                         entries [NUM_RS_ENTRIES],
    input logic                              rs_full,
    input logic [$clog2(NUM_RS_ENTRIES)-1:0] best,
    input logic                              best_valid
);

    int unsigned fail_count = 0;
    logic        age_clash;

    always_comb begin
        age_clash = 1'b0;
        for (int i = 0; i < NUM_RS_ENTRIES; i++) begin
            for (int j = i + 1; j < NUM_RS_ENTRIES; j++) begin
                if (entries[i].valid && entries[j].valid && entries[i].age == entries[j].age)
                    age_clash = 1'b1;
            end
        end
    end

    unique_ages: assert property (@(posedge clk) disable iff (reset) !age_clash)
        else begin $error("two valid entries share an age"); fail_count++; end

    issue_from_valid: assert property (@(posedge clk) disable iff (reset)
        best_valid |-> entries[best].valid)
        else begin $error("issue selected an empty slot"); fail_count++; end

    // A full station only loses an entry through issue.
    full_no_free: assert property (@(posedge clk) disable iff (reset)
        rs_full && !best_valid |=> rs_full)
        else begin $error("rs_full fell without an issue"); fail_count++; end

endmodule

bind rs_table rs_issue_assert #(.NUM_RS_ENTRIES(NUM_RS_ENTRIES)) u_assert (
    .clk        (clk),
    .reset      (reset),
    .entries    (rs_q),
    .rs_full    (rs_full),
    .best       (sel.best),
    .best_valid (sel.best_valid)
);

/* rs_issue_tb.sv */
`timescale 1ns/1ps

module rs_issue_tb import rs_issue_pkg::*; ();

    localparam int NUM_RS_ENTRIES = 16;
    localparam int RAND_CYCLES    = 2000;
    localparam int DRAIN_MAX      = 24;
    // Reset, five directed tests of at most 50 cycles, random run, writeback sweep, drain.
    localparam int TOTAL_CYCLES   = 4 + 5 * 50 + RAND_CYCLES + PHY_REGS + DRAIN_MAX;

    logic     clk;
    logic     reset;
    logic     dispatch_valid;
    opcode_t  dispatch_opcode;
    phy_tag_t dispatch_rs1;
    phy_tag_t dispatch_rs2;
    phy_tag_t dispatch_rd;
    logic     rs_full;
    logic     wb_valid;
    phy_tag_t wb_phy;
    logic     issue_valid;
    opcode_t  issue_opcode;
    phy_tag_t issue_rs1;
    phy_tag_t issue_rs2;
    phy_tag_t issue_rd;

    rs_entry_t m_q [$];  // Model station, oldest first.
    logic      m_ready [PHY_REGS];
    logic      pre_ready [PHY_REGS];
    rs_entry_t last_act;
    opcode_t   op_table [10];
    integer    seed;
    string     cur_test;
    int        n_tests;
    int        n_checks;
    int        n_errors;
    int        test_errs;
    int        assert_fails;

    rs_issue_top #(.NUM_RS_ENTRIES(NUM_RS_ENTRIES), .PHY_REGS(PHY_REGS)) DUT (.*);

    always #4 clk = ~clk;

    task automatic start_test(input string name);
        cur_test  = name;
        test_errs = 0;
    endtask

    task automatic finish_test();
        n_tests++;
        $display("test %s finished with %0d errors", cur_test, test_errs);
    endtask

    task automatic check_issue(input rs_entry_t want, input rs_entry_t got);
        n_checks++;
        if (got !== want) begin
            $display("ERR %s: issue expected %h actual %h", cur_test, want, got);
            n_errors++;
            test_errs++;
        end
    endtask

    task automatic check_full(input logic want, input logic got);
        n_checks++;
        if (got !== want) begin
            $display("ERR %s: rs_full expected %b actual %b", cur_test, want, got);
            n_errors++;
            test_errs++;
        end
    endtask

    // Actual bit is what the issue stream shows about the tag.
    task automatic check_ready(input phy_tag_t tag, input logic want, input logic got);
        n_checks++;
        if (got !== want) begin
            $display("ERR %s: ready p%0d expected %b actual %b", cur_test, tag, want, got);
            n_errors++;
            test_errs++;
        end
    endtask

    // Index into m_q of the entry that issues, -1 for none.
    function automatic int pick_issue();
        logic r1;
        logic r2;
        logic cand;
        for (int i = 0; i < m_q.size(); i++) begin
            r1 = m_ready[m_q[i].rs1_phy];
            r2 = m_ready[m_q[i].rs2_phy];
            case (m_q[i].opcode)
                LOAD:                    return r1 ? i : -1;
                STORE:                   return (r1 && r2) ? i : -1;
                JAL, LUI, AUIPC, SYSTEM: return i;
                OP_IMM, JALR:            cand = r1;
                OP, BRANCH:              cand = r1 && r2;
                default:                 cand = 1'b0;
            endcase
            if (cand) return i;
        end
        return -1;
    endfunction

    function automatic void model_update(input logic dv, input rs_entry_t e, input logic wv,
                                         input phy_tag_t wp, input int win);
        logic accept;
        accept = dv && (m_q.size() < NUM_RS_ENTRIES);
        if (win >= 0) m_q.delete(win);
        if (accept) m_q.push_back(e);
        if (wv) m_ready[wp] = 1'b1;
        if (accept) m_ready[e.rd_phy] = 1'b0;  // Dispatch clear beats writeback.
    endfunction

    task automatic step(input logic dv, input opcode_t op, input phy_tag_t r1, input phy_tag_t r2,
                        input phy_tag_t rd, input logic wv, input phy_tag_t wp);
        rs_entry_t want;
        rs_entry_t e;
        int        win;
        @(posedge clk);
        dispatch_valid  <= dv;
        dispatch_opcode <= op;
        dispatch_rs1    <= r1;
        dispatch_rs2    <= r2;
        dispatch_rd     <= rd;
        wb_valid        <= wv;
        wb_phy          <= wp;
        @(negedge clk);
        win  = pick_issue();
        want = '0;
        if (win >= 0) begin
            want     = m_q[win];
            want.age = '0;  // Not visible on the issue port.
        end
        last_act = '0;
        if (issue_valid) begin
            last_act.valid   = 1'b1;
            last_act.opcode  = issue_opcode;
            last_act.rs1_phy = issue_rs1;
            last_act.rs2_phy = issue_rs2;
            last_act.rd_phy  = issue_rd;
        end
        check_issue(want, last_act);
        check_full(m_q.size() == NUM_RS_ENTRIES, rs_full);
        pre_ready = m_ready;
        e         = '{valid: 1'b1, opcode: op, rs1_phy: r1, rs2_phy: r2, rd_phy: rd, age: '0};
        model_update(dv, e, wv, wp, win);
    endtask

    task automatic send(input opcode_t op, input phy_tag_t r1, input phy_tag_t r2,
                        input phy_tag_t rd);
        step(1'b1, op, r1, r2, rd, 1'b0, '0);
    endtask

    task automatic idle();
        step(1'b0, LUI, '0, '0, '0, 1'b0, '0);
    endtask

    task automatic writeback(input phy_tag_t tag);
        step(1'b0, LUI, '0, '0, '0, 1'b1, tag);
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (m_q.size() != 0 && n < DRAIN_MAX) begin
            idle();
            n++;
        end
        if (m_q.size() != 0) begin
            $display("%s: station still holds entries after %0d cycles", cur_test, DRAIN_MAX);
            n_errors++;
            test_errs++;
        end
    endtask

    task automatic in_order();
        start_test("in_order");
        for (int i = 0; i < 10; i++) begin
            send(op_table[i], phy_tag_t'(i), phy_tag_t'(16 + i), phy_tag_t'(32 + i));
        end
        drain();
        finish_test();
    endtask

    task automatic op_bypass();
        start_test("op_bypass");
        send(LUI, 6'd1, 6'd1, 6'd10);  // p10 pending.
        send(OP, 6'd1, 6'd10, 6'd40);
        send(JAL, 6'd0, 6'd0, 6'd41);
        send(OP_IMM, 6'd2, 6'd0, 6'd42);
        idle();
        idle();
        writeback(6'd10);
        idle();
        check_ready(6'd10, pre_ready[10], last_act.valid && last_act.opcode == OP);
        drain();
        finish_test();
    endtask

    task automatic mem_block(input string name, input opcode_t op, input phy_tag_t tag);
        start_test(name);
        send(LUI, 6'd1, 6'd1, tag);
        if (op == LOAD) send(LOAD, tag, 6'd0, 6'd43);
        else send(STORE, 6'd4, tag, 6'd46);
        send(OP_IMM, 6'd3, 6'd0, 6'd44);
        send(OP, 6'd5, 6'd6, 6'd45);
        idle();
        idle();
        check_ready(tag, pre_ready[tag], last_act.valid);  // Head blocked.
        writeback(tag);
        idle();
        check_ready(tag, pre_ready[tag], last_act.valid);
        drain();
        finish_test();
    endtask

    task automatic fill_station();
        start_test("fill_station");
        send(LUI, 6'd1, 6'd1, 6'd20);
        for (int i = 0; i < NUM_RS_ENTRIES; i++) begin
            send(OP, 6'd7, 6'd20, phy_tag_t'(48 + i));
        end
        send(OP_IMM, 6'd1, 6'd1, 6'd7);  // Dropped, p7 stays ready.
        idle();
        writeback(6'd20);
        drain();
        finish_test();
    endtask

    task automatic random_mix();
        int   r;
        int   t;
        logic dv;
        phy_tag_t rd;
        phy_tag_t wp;
        start_test("random_mix");
        for (int c = 0; c < RAND_CYCLES; c++) begin
            r  = $random(seed);
            t  = $random(seed);
            dv = r[0] && (m_q.size() < NUM_RS_ENTRIES);
            rd = phy_tag_t'(t >> 12);
            wp = (r[3:2] == 2'b00) ? rd : phy_tag_t'(t >> 18);
            step(dv, op_table[($unsigned(r) >> 4) % 10], phy_tag_t'(t), phy_tag_t'(t >> 6),
                 rd, r[1], wp);
        end
        for (int i = 0; i < PHY_REGS; i++) writeback(phy_tag_t'(i));
        drain();
        finish_test();
    endtask

    initial begin
        clk             = 1'b0;
        reset           = 1'b1;
        dispatch_valid  = 1'b0;
        dispatch_opcode = LUI;
        dispatch_rs1    = '0;
        dispatch_rs2    = '0;
        dispatch_rd     = '0;
        wb_valid        = 1'b0;
        wb_phy          = '0;
        seed            = 32'ha83;
        n_tests         = 0;
        n_checks        = 0;
        n_errors        = 0;
        op_table = '{LOAD, STORE, BRANCH, JAL, JALR, LUI, AUIPC, OP_IMM, OP, SYSTEM};
        for (int i = 0; i < PHY_REGS; i++) m_ready[i] = 1'b1;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        in_order();
        op_bypass();
        mem_block("load_block", LOAD, 6'd12);
        mem_block("store_block", STORE, 6'd13);
        fill_station();
        random_mix();
        assert_fails = DUT.u_table.u_assert.fail_count;
        $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
                 n_tests, n_checks, n_errors, assert_fails);
        if (n_errors == 0 && assert_fails == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        #((TOTAL_CYCLES + 100) * 8);
        $display("Watchdog expired at %0t, tests did not complete", $time);
        $display("Checks failed");
        $finish;
    end

endmodule

/* rs_issue_top.f */
rs_issue_pkg.sv
rs_select_if.sv
prf_scoreboard.sv
rs_table.sv
issue_select.sv
rs_issue_top.sv
rs_issue_assert.sv
rs_issue_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it, result taken from the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f rs_issue_top.f --top-module rs_issue_tb -o rs_issue_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/rs_issue_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "All checks passed" sim.log; then
    exit 0
fi
exit 1
